// File: src/ow_pkg.sv
// shared types and constants for the 1-wire sensor poller

package ow_pkg;

  // slot kinds, one per byte slot of the script
  typedef enum logic [3:0] {
    OP_IDLE_READ    = 4'd0,  // send ff, read back what the device pulls
    OP_RESET        = 4'd1,  // bus reset pulse, whole byte low
    OP_PRESENCE     = 4'd2,  // released, device answers with presence
    OP_READ_ROM     = 4'd3,
    OP_SKIP_ROM     = 4'd4,
    OP_READ_SCRATCH = 4'd5,
    OP_CONVERT      = 4'd6,
    OP_DELAY        = 4'd7   // conversion wait, no drive
  } ow_op_e;

  // 1-wire command bytes
  localparam logic [7:0] CMD_READ_ROM     = 8'h33;
  localparam logic [7:0] CMD_SKIP_ROM     = 8'hcc;
  localparam logic [7:0] CMD_READ_SCRATCH = 8'hbe;
  localparam logic [7:0] CMD_CONVERT      = 8'h44;

  // script layout
  localparam int SLOT_IDX_W = 6;                 // 64 byte slots per frame
  localparam int SCRIPT_LEN = 1 << SLOT_IDX_W;
  localparam logic [SLOT_IDX_W-1:0] DELAY_SLOT = SLOT_IDX_W'(SCRIPT_LEN - 1);

  // apb register map, byte offsets
  localparam logic [11:0] REG_CTRL    = 12'h000;  // bit 0 run
  localparam logic [11:0] REG_STATUS  = 12'h004;  // slot index, delay flag
  localparam logic [11:0] RESULT_BASE = 12'h100;  // byte n at base + 4n

endpackage

// File: src/ow_script_decode.sv
`timescale 1ns/1ps

// fixed command script, slot index in, slot kind and wire byte out
// purely combinational, the engine latches what it needs
module ow_script_decode import ow_pkg::*; (
  input  logic [SLOT_IDX_W-1:0] slot_idx,
  output ow_op_e                op,
  output logic [7:0]            cmd_byte
);

  // script table
  always_comb begin
    case (slot_idx)
      // pass 1, read the scratchpad
      6'd0:    op = OP_RESET;
      6'd1:    op = OP_PRESENCE;
      6'd2:    op = OP_SKIP_ROM;       // cc
      6'd3:    op = OP_READ_SCRATCH;   // be, scratchpad bytes follow
      // pass 2, serial number
      6'd16:   op = OP_RESET;
      6'd17:   op = OP_PRESENCE;
      6'd18:   op = OP_READ_ROM;       // 33, family + serial + crc follow
      // pass 3, kick off a conversion
      6'd27:   op = OP_RESET;
      6'd28:   op = OP_PRESENCE;
      6'd29:   op = OP_SKIP_ROM;       // cc
      6'd30:   op = OP_CONVERT;        // 44
      // last slot holds the conversion wait
      6'd63:   op = OP_DELAY;
      default: op = OP_IDLE_READ;      // read slots in between
    endcase
  end

  // byte shifted out for each slot kind
  always_comb begin
    case (op)
      OP_IDLE_READ:    cmd_byte = 8'hff;  // all ones, device pulls the zeros
      OP_RESET:        cmd_byte = 8'h00;  // unused
      OP_PRESENCE:     cmd_byte = 8'h00;  // unused
      OP_READ_ROM:     cmd_byte = CMD_READ_ROM;
      OP_SKIP_ROM:     cmd_byte = CMD_SKIP_ROM;
      OP_READ_SCRATCH: cmd_byte = CMD_READ_SCRATCH;
      OP_CONVERT:      cmd_byte = CMD_CONVERT;
      OP_DELAY:        cmd_byte = 8'h00;  // unused
      default:         cmd_byte = 8'h00;
    endcase
  end

  // the engine decodes slot kinds by value, anything past OP_DELAY
  // would run as a plain read slot without notice
  always_comb begin
    a_op_range: assert (op <= OP_DELAY)
      else $error("script decode gave opcode %0d outside the enum", op);
  end

endmodule

// File: src/ow_bit_engine.sv
`timescale 1ns/1ps

// bit timing engine
// tick = 2**TICK_DIV_LOG2 clocks, bit = 15 ticks, byte slot = 8 bits
// delay slot = CONVERT_TICKS ticks, wire released
module ow_bit_engine import ow_pkg::*; #(
  parameter int TICK_DIV_LOG2 = 9,
  parameter int CONVERT_TICKS = 19200
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  run,
  input  ow_op_e                op,
  input  logic [7:0]            cmd_byte,
  input  logic                  ow_in,
  output logic [SLOT_IDX_W-1:0] slot_idx,
  output logic                  drive_low,
  output logic                  wr_en,
  output logic [7:0]            wr_data
);

  localparam int BIT_TICKS   = 15;
  localparam int SAMPLE_TICK = 3;
  // phase counter must also cover the long delay slot
  localparam int PH_W = (CONVERT_TICKS > 16) ? $clog2(CONVERT_TICKS) : 4;

  logic [TICK_DIV_LOG2-1:0] div;
  logic                     tick;
  logic [PH_W-1:0]          phase;      // tick within bit
  logic [PH_W-1:0]          ph_last;
  logic [PH_W-1:0]          phase_nx;
  logic [2:0]               bit_cnt;    // bit within byte
  logic                     act;        // frame running, set on first tick after run
  logic                     load_q;     // one clock after byte end, decode has new slot
  ow_op_e                   kind;       // latched slot kind
  logic [7:0]               shreg;      // out bits at [0], samples enter at [7]
  logic [7:0]               shreg_nx;
  logic                     ow_s1;
  logic                     ow_s2;
  logic                     samp;
  logic                     bit_end;
  logic                     byte_end;
  logic                     out_nx;

  // drive rule for one tick of a slot
  // last tick of a data bit always released for recovery
  function automatic logic want_low(ow_op_e k, logic [PH_W-1:0] ph, logic b);
    logic data_slot;
    data_slot = (k != OP_RESET) && (k != OP_PRESENCE) && (k != OP_DELAY);
    return (k == OP_RESET) ||
           (data_slot && (ph != PH_W'(BIT_TICKS - 1)) && ((ph == PH_W'(0)) || !b));
  endfunction

  // tick divider, free running
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      div  <= '0;
      tick <= 1'b0;
    end else begin
      div  <= div + 1'b1;
      tick <= (div == '0);
    end
  end

  // two flops on the wire before use
  always_ff @(posedge clk) begin
    ow_s1 <= ow_in;
    ow_s2 <= ow_s1;
  end

  assign ph_last  = (kind == OP_DELAY) ? PH_W'(CONVERT_TICKS - 1) : PH_W'(BIT_TICKS - 1);
  assign bit_end  = tick && act && run && (phase == ph_last);
  assign byte_end = bit_end && ((kind == OP_DELAY) || (bit_cnt == 3'd7));  // delay is one long bit
  assign phase_nx = (phase == ph_last) ? PH_W'(0) : phase + 1'b1;
  assign shreg_nx = {samp, shreg[7:1]};
  assign out_nx   = (phase == ph_last) ? shreg[1] : shreg[0];  // next bit after a bit end

  // ram write lands on the last bit end, slot_idx still the old slot
  assign wr_en   = byte_end;
  assign wr_data = shreg_nx;

  // counters, slot kind and wire drive
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase     <= '0;
      bit_cnt   <= '0;
      slot_idx  <= '0;
      act       <= 1'b0;
      load_q    <= 1'b0;
      kind      <= OP_IDLE_READ;
      drive_low <= 1'b0;
    end else begin
      load_q <= byte_end;
      if (tick) begin
        if (!run) begin  // stop, back to slot 0
          phase     <= '0;
          bit_cnt   <= '0;
          slot_idx  <= '0;
          act       <= 1'b0;
          drive_low <= 1'b0;
        end else if (!act) begin  // first tick of a new frame
          act       <= 1'b1;
          drive_low <= want_low(kind, PH_W'(0), shreg[0]);
        end else begin
          phase <= phase_nx;
          if (bit_end) begin
            bit_cnt <= byte_end ? 3'd0 : bit_cnt + 3'd1;
          end
          if (byte_end) begin
            slot_idx <= slot_idx + 1'b1;  // wraps 63 -> 0
          end
          // next kind unknown at a byte end, hold released one clock
          drive_low <= byte_end ? 1'b0 : want_low(kind, phase_nx, out_nx);
        end
      end else if (load_q && run) begin
        drive_low <= want_low(op, PH_W'(0), cmd_byte[0]);  // start of new slot
      end
      if (!act || load_q) begin
        kind <= op;
      end
    end
  end

  // sample and shift path
  always_ff @(posedge clk) begin
    if (tick && act && (phase == PH_W'(SAMPLE_TICK))) begin
      samp <= ow_s2;
    end
    if (!act || load_q) begin
      shreg <= cmd_byte;
    end else if (bit_end) begin
      shreg <= shreg_nx;
    end
  end

  // slot 63 must be quiet on the wire whatever the script says
  a_no_drive_in_delay: assert property (
    @(posedge clk) disable iff (rst) (slot_idx == DELAY_SLOT) |-> !drive_low
  ) else $error("wire driven during the delay slot");

  a_wr_on_tick: assert property (
    @(posedge clk) disable iff (rst) wr_en |-> tick
  ) else $error("result write off the tick grid");

endmodule

// File: src/ow_result_ram.sv
`timescale 1ns/1ps

// 64 x 8 result store plus the consistency flag
module ow_result_ram import ow_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr_en,
  input  logic [SLOT_IDX_W-1:0] slot_idx,
  input  logic [7:0]            wr_data,
  input  logic [SLOT_IDX_W-1:0] rd_addr,
  input  logic                  rd_strobe,
  output logic [7:0]            rd_data,
  output logic                  rd_stale
);

  logic [7:0] mem [0:SCRIPT_LEN-1];
  logic [7:0] rd_q;
  logic       stale_q;

  // write at the current slot, registered read on strobe
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[slot_idx] <= wr_data;
    end
    if (rd_strobe) begin
      rd_q <= mem[rd_addr];
    end
  end

  assign rd_data = rd_q;

  // reading byte 0 opens a read pass
  // only clean when the frame sits in the delay slot, nothing gets written there
  // until the wrap, so bytes 0..62 stay together
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stale_q <= 1'b1;  // nothing valid yet
    end else if (rd_strobe && (rd_addr == '0)) begin
      stale_q <= (slot_idx != DELAY_SLOT);
    end
  end

  assign rd_stale = stale_q;  // held until the next byte 0 read

endmodule

// File: src/ow_apb_regs.sv
`timescale 1ns/1ps

// apb slave, ctrl / status / result window
// result reads take one wait state for the registered ram port
module ow_apb_regs import ow_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [11:0]           paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  run,
  output logic [SLOT_IDX_W-1:0] rd_addr,
  output logic                  rd_strobe,
  input  logic [7:0]            rd_data,
  input  logic                  rd_stale,
  input  logic [SLOT_IDX_W-1:0] slot_idx
);

  localparam logic [11:0] RESULT_END = RESULT_BASE + 12'(4 * SCRIPT_LEN);

  logic setup;
  logic access;
  logic hit_ctrl;
  logic hit_stat;
  logic hit_res;
  logic res_rd;
  logic err;
  logic wait_q;  // wait cycle of a result read done

  assign setup    = psel && !penable;
  assign access   = psel && penable;
  assign hit_ctrl = (paddr == REG_CTRL);
  assign hit_stat = (paddr == REG_STATUS);
  assign hit_res  = (paddr >= RESULT_BASE) && (paddr < RESULT_END) && (paddr[1:0] == 2'b00);
  assign res_rd   = hit_res && !pwrite;
  // unmapped, or write to a read only register
  assign err      = !(hit_ctrl || hit_stat || hit_res) || (pwrite && (hit_stat || hit_res));

  // ram read launched in the setup phase
  assign rd_addr   = paddr[2 +: SLOT_IDX_W];
  assign rd_strobe = setup && res_rd;

  assign pready  = access && (!res_rd || wait_q);
  assign pslverr = pready && err;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= access && res_rd && !wait_q;  // high for the second access cycle only
    end
  end

  // run bit
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run <= 1'b0;
    end else if (access && pwrite && hit_ctrl) begin
      run <= pwdata[0];
    end
  end

  // read mux
  always_comb begin
    prdata = '0;
    if (hit_ctrl) begin
      prdata[0] = run;
    end else if (hit_stat) begin
      prdata[SLOT_IDX_W-1:0] = slot_idx;
      prdata[8]              = (slot_idx == DELAY_SLOT);  // results readable now
    end else if (hit_res) begin
      prdata[7:0] = rd_data;
      prdata[8]   = rd_stale;
    end
  end

  a_pready_in_access: assert property (
    @(posedge clk) disable iff (rst) pready |-> access
  ) else $error("pready outside an access phase");

  // a result read never completes in its first access cycle
  a_res_wait: assert property (
    @(posedge clk) disable iff (rst) (pready && res_rd) |-> $past(access && !pready)
  ) else $error("result read completed without its wait state");

endmodule

// File: src/ow_sensor_top.sv
`timescale 1ns/1ps

// 1-wire temperature poller, apb side plus open drain pin
module ow_sensor_top import ow_pkg::*; #(
  parameter int TICK_DIV_LOG2 = 9,      // 2 in sim
  parameter int CONVERT_TICKS = 19200   // 40 in sim
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  inout  wire         ow_pin
);

  logic                  run;
  logic [SLOT_IDX_W-1:0] slot_idx;
  ow_op_e                op;
  logic [7:0]            cmd_byte;
  logic                  drive_low;
  logic                  ow_in;
  logic                  wr_en;
  logic [7:0]            wr_data;
  logic [SLOT_IDX_W-1:0] rd_addr;
  logic                  rd_strobe;
  logic [7:0]            rd_data;
  logic                  rd_stale;

  // open drain, pull up is external
  assign ow_pin = drive_low ? 1'b0 : 1'bz;
  assign ow_in  = ow_pin;

  ow_script_decode u_decode (
    .slot_idx (slot_idx),
    .op       (op),
    .cmd_byte (cmd_byte)
  );

  ow_bit_engine #(
    .TICK_DIV_LOG2 (TICK_DIV_LOG2),
    .CONVERT_TICKS (CONVERT_TICKS)
  ) u_engine (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .op        (op),
    .cmd_byte  (cmd_byte),
    .ow_in     (ow_in),
    .slot_idx  (slot_idx),
    .drive_low (drive_low),
    .wr_en     (wr_en),
    .wr_data   (wr_data)
  );

  ow_result_ram u_ram (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .slot_idx  (slot_idx),
    .wr_data   (wr_data),
    .rd_addr   (rd_addr),
    .rd_strobe (rd_strobe),
    .rd_data   (rd_data),
    .rd_stale  (rd_stale)
  );

  ow_apb_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .run       (run),
    .rd_addr   (rd_addr),
    .rd_strobe (rd_strobe),
    .rd_data   (rd_data),
    .rd_stale  (rd_stale),
    .slot_idx  (slot_idx)
  );

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps

// clock and power-on reset for the testbench
module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst = 1'b0;  // release just after the edge
  end

endmodule

// File: sim/ow_device_model.sv
`timescale 1ns/1ps

// behavioral 1-wire slave, decodes skip / read scratchpad / read rom
module ow_device_model #(
  parameter int TICK_NS = 400
) (
  inout wire  pin,
  input logic en
);

  localparam time RST_MIN = time'(30 * TICK_NS);  // longer than any 0 bit
  localparam time ONE_MAX = time'(4 * TICK_NS);

  logic       pull;
  logic [7:0] scratch [0:8];
  logic [7:0] rom [0:7];
  logic [7:0] cmd;
  logic [2:0] cmd_bits;
  logic [6:0] resp_bits;
  logic       bitv;
  int         mode;  // 0 idle, 1 command, 2 scratchpad out, 3 rom out
  time        t_fall;
  time        dur;

  assign pin = pull ? 1'b0 : 1'bz;

  initial begin
    pull = 1'b0;
    mode = 0;
    cmd = 8'h00;
    cmd_bits = 3'd0;
    resp_bits = 7'd0;
    scratch = '{8'h50, 8'h05, 8'h4b, 8'h46, 8'h7f, 8'hff, 8'h0c, 8'h10, 8'h1c};
    rom = '{8'h28, 8'ha1, 8'hb2, 8'hc3, 8'hd4, 8'he5, 8'hf6, 8'h7a};
  end

  always begin
    @(negedge pin);
    t_fall = $time;
    @(posedge pin);
    dur = $time - t_fall;
    if (dur > RST_MIN) begin  // bus reset
      mode = en ? 1 : 0;
      cmd_bits = 3'd0;
      resp_bits = 7'd0;
      if (en) begin
        pull = 1'b1;  // presence over the first four bit samples
        #(60 * TICK_NS);
        pull = 1'b0;
      end
    end else if (mode == 1) begin
      cmd = {(dur < ONE_MAX), cmd[7:1]};  // lsb first
      if (cmd_bits == 3'd7) begin
        mode = (cmd == 8'hcc) ? 1 : (cmd == 8'hbe) ? 2 : (cmd == 8'h33) ? 3 : 0;
      end
      cmd_bits = cmd_bits + 3'd1;
    end else if (mode >= 2) begin
      bitv = (mode == 2) ? scratch[resp_bits[6:3]][resp_bits[2:0]]
                         : rom[resp_bits[5:3]][resp_bits[2:0]];
      if ((mode == 2 && resp_bits == 7'd71) || (mode == 3 && resp_bits == 7'd63)) mode = 0;
      resp_bits = resp_bits + 7'd1;
      if (!bitv) begin
        pull = 1'b1;  // hold over the master's sample point
        #(5 * TICK_NS);
        pull = 1'b0;
      end
    end
  end

endmodule

// File: sim/tb_ow_sensor.sv
`timescale 1ns/1ps

module tb_ow_sensor import ow_pkg::*; ();

  localparam int TICK_DIV_LOG2 = 2;
  localparam int CONVERT_TICKS = 40;
  localparam int CLK_NS        = 100;
  localparam int N_BYTES       = 31;
  localparam int TICK_CLKS     = 1 << TICK_DIV_LOG2;
  localparam int FRAME_CLKS    = 64 * 8 * 15 * TICK_CLKS + CONVERT_TICKS * TICK_CLKS;
  localparam int WATCHDOG_NS   = (3 * FRAME_CLKS + 5000) * CLK_NS;  // three frames + margin

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        dev_en;   // device model answers when high
  wire         ow_pin;

  logic [7:0]  gold_present [0:N_BYTES-1];
  logic [7:0]  gold_absent [0:N_BYTES-1];
  logic [31:0] gold_ctrl_rst;
  logic [31:0] gold_stat_rst;
  logic [31:0] gold_ctrl_run;
  logic [31:0] gold_stale;
  int          errors;
  int          checks;
  int          last_waits;  // wait cycles of the last transfer
  logic [31:0] rd;
  logic        err;

  pullup (ow_pin);  // bus pull up

  tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(4)) u_clk (.clk(clk), .rst(rst));

  ow_sensor_top #(
    .TICK_DIV_LOG2 (TICK_DIV_LOG2),
    .CONVERT_TICKS (CONVERT_TICKS)
  ) DUT (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .ow_pin(ow_pin)
  );

  ow_device_model #(.TICK_NS(TICK_CLKS * CLK_NS)) u_dev (.pin(ow_pin), .en(dev_en));

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // one apb transfer entered and left 1 ns after a rising edge
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic perr);
    psel = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1 penable = 1'b1;  // access phase
    last_waits = 0;
    @(negedge clk);  // sample mid cycle
    while (!pready && last_waits < 16) begin
      @(negedge clk);
      last_waits++;
    end
    if (!pready) begin
      errors++;
      $display("APB transfer to offset %03h never completed", addr);
    end
    rdata = prdata;
    perr = pslverr;
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  // poll status until the delay slot or a given slot shows up
  task automatic wait_slot(input logic want_delay, input int slot);
    logic [31:0] st;
    logic e;
    logic any_err;
    apb_xfer(1'b0, REG_STATUS, 32'd0, st, e);
    any_err = e;
    while ((want_delay && !st[8]) || (!want_delay && st[5:0] != slot[5:0])) begin
      apb_xfer(1'b0, REG_STATUS, 32'd0, st, e);
      any_err = any_err | e;
    end
    compare("status poll pslverr", 32'd0, {31'd0, any_err});  // status reads are legal
  endtask

  task automatic check_results(input logic present, input string tag);
    logic [31:0] d;
    logic e;
    int i;
    for (i = 0; i < N_BYTES; i++) begin
      apb_xfer(1'b0, RESULT_BASE + 12'(4 * i), 32'd0, d, e);
      compare($sformatf("%s byte %0d", tag, i),
              {24'd0, present ? gold_present[i] : gold_absent[i]}, d);  // bit 8 clear
      compare($sformatf("%s byte %0d pslverr", tag, i), 32'd0, {31'd0, e});
    end
  endtask

  task automatic watch_pin_high(input int cycles, input string tag);
    int n;
    int bad;
    bad = 0;
    for (n = 0; n < cycles; n++) begin
      @(negedge clk);
      if (ow_pin !== 1'b1 && bad == 0) bad = 1;  // report once
    end
    checks++;
    if (bad != 0) begin
      errors++;
      $display("%s: the 1-wire pin went low while it should stay idle", tag);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic read_golden();
    int fd;
    int r;
    int i;
    int p0;
    int p1;
    logic [8*160-1:0] line;
    fd = $fopen("sim/ow_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open the golden file sim/ow_golden.txt");
    end else begin
      r = $fgets(line, fd);  // two header lines
      r = $fgets(line, fd);
      r = $fscanf(fd, "%d %d", p0, p1);
      compare("golden tick_div_log2", TICK_DIV_LOG2, p0);
      compare("golden convert_ticks", CONVERT_TICKS, p1);
      for (i = 0; i < N_BYTES; i++) r = $fscanf(fd, "%h", gold_present[i]);
      for (i = 0; i < N_BYTES; i++) r = $fscanf(fd, "%h", gold_absent[i]);
      r = $fscanf(fd, "%h %h %h %h", gold_ctrl_rst, gold_stat_rst, gold_ctrl_run, gold_stale);
      if (r != 4) begin
        errors++;
        $display("golden file sim/ow_golden.txt ends before the register values");
      end
      $fclose(fd);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t, the run took longer than three frames", $time);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 12'h000;
    pwdata = 32'd0;
    dev_en = 1'b1;
    errors = 0;
    checks = 0;
    read_golden();
    wait (rst == 1'b0);
    @(posedge clk);
    #1;

    // idle after reset
    compare("reset pready", 32'd0, {31'd0, pready});
    compare("reset pslverr", 32'd0, {31'd0, pslverr});
    apb_xfer(1'b0, REG_CTRL, 32'd0, rd, err);
    compare("reset ctrl", gold_ctrl_rst, rd);
    compare("ctrl wait states", 32'd0, last_waits);  // no wait state on ctrl
    apb_xfer(1'b0, REG_STATUS, 32'd0, rd, err);
    compare("reset status", gold_stat_rst, rd);
    watch_pin_high(2000, "idle after reset");

    // read results in the delay slot with the device present
    apb_xfer(1'b1, REG_CTRL, 32'd1, rd, err);
    wait_slot(1'b1, 0);
    check_results(1'b1, "present");
    compare("result wait states", 32'd1, last_waits);

    // byte 0 outside the delay slot is flagged stale
    wait_slot(1'b0, 0);
    apb_xfer(1'b0, RESULT_BASE, 32'd0, rd, err);
    compare("stale flag", gold_stale, {31'd0, rd[8]});

    // device gone before this frame's reset ends
    dev_en = 1'b0;
    wait_slot(1'b1, 0);
    check_results(1'b0, "absent");

    // apb errors leave the run bit alone
    apb_xfer(1'b0, 12'h008, 32'd0, rd, err);
    compare("unmapped read pslverr", 32'd1, {31'd0, err});
    apb_xfer(1'b1, RESULT_BASE, 32'h5a, rd, err);  // bit 0 clear, would stop a bad ctrl decode
    compare("result write pslverr", 32'd1, {31'd0, err});
    apb_xfer(1'b0, REG_CTRL, 32'd0, rd, err);
    compare("ctrl after errors", gold_ctrl_run, rd);

    // stop mid frame
    wait_slot(1'b0, 5);
    apb_xfer(1'b1, REG_CTRL, 32'd0, rd, err);
    repeat (TICK_CLKS) @(posedge clk);  // one tick for drive_low to fall
    #1;
    watch_pin_high(2000, "after run cleared");
    apb_xfer(1'b0, REG_STATUS, 32'd0, rd, err);
    compare("status after stop", 32'd0, rd);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
src/ow_pkg.sv
src/ow_script_decode.sv
src/ow_bit_engine.sv
src/ow_result_ram.sv
src/ow_apb_regs.sv
src/ow_sensor_top.sv
sim/tb_clk_gen.sv
sim/ow_device_model.sv
sim/tb_ow_sensor.sv

// File: run_sim.sh
#!/bin/sh
# build and run the 1-wire poller testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_ow_sensor \
  --Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Simulation PASSED" sim.log; then
  echo "simulation ended without a pass result"
  exit 1
fi
exit 0

// File: sim/ow_golden.txt
# line 3 tick_div_log2 convert_ticks, line 4 bytes 0..30 device present (hex),
# line 5 bytes 0..30 device absent, line 6 ctrl_rst status_rst ctrl_run stale_bit
2 40
00 f0 cc be 50 05 4b 46 7f ff 0c 10 1c ff ff ff 00 f0 33 28 a1 b2 c3 d4 e5 f6 7a 00 f0 cc 44
00 ff cc be ff ff ff ff ff ff ff ff ff ff ff ff 00 ff 33 ff ff ff ff ff ff ff ff 00 ff cc 44
0 0 1 1
